// ==== common/ndn_params.svh ====
// Table sizes and packet byte counts for the NDN router, included by RTL needing them
`ifndef NDN_PARAMS_SVH
`define NDN_PARAMS_SVH

// Name and payload sizes in bytes
`define NDN_PREFIX_BYTES 8
`define NDN_DATA_BYTES 4

// Hash width, also log2 of the FIB row size
`define NDN_HASH_BITS 6

// One FIB row per possible prefix length
`define NDN_NUM_LENGTHS 64

`define NDN_PIT_DEPTH 4

// Emitted packet sizes, interest is the longest
`define NDN_OUT_MAX_BYTES (1 + 2 * `NDN_PREFIX_BYTES)
`define NDN_DATA_OUT_BYTES (1 + `NDN_PREFIX_BYTES + `NDN_DATA_BYTES)

`endif

// ==== common/ndn_pkg.sv ====
// Shared types for the NDN router, referenced by scoped name from the RTL and the testbench
package ndn_pkg;

    // Packet kind in the top two bits of the metadata byte
    typedef enum logic [1:0] {
        KIND_ROUTE    = 2'd0,
        KIND_INTEREST = 2'd1,
        KIND_DATA     = 2'd2
    } ndn_kind_e;

    // Metadata byte with kind on top and prefix length in bits below
    typedef struct packed {
        ndn_kind_e  kind;
        logic [5:0] len;
    } ndn_meta_t;

    // PIT request type
    typedef enum logic {
        PIT_INSERT = 1'b0,
        PIT_CLAIM  = 1'b1
    } pit_op_e;

    typedef struct packed {
        logic        valid;
        pit_op_e     op;
        logic [63:0] prefix;
    } pit_req_t;

    // Hit means already pending on insert, found and cleared on claim
    typedef struct packed {
        logic done;
        logic hit;
    } pit_rsp_t;

    // FIB parser and serializer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_META,
        ST_PREFIX,
        ST_PAYLOAD,
        ST_HASH,
        ST_PROBE,
        ST_PIT_WAIT,
        ST_EMIT
    } fib_state_e;

endpackage

// ==== hdl/prefix_hash.sv ====
// Registered XOR-fold hash of a masked prefix, used by the FIB to pick a row bit
`timescale 1ns/10ps

`include "ndn_params.svh"

module prefix_hash (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [63:0]               prefix,
    output logic [`NDN_HASH_BITS-1:0] hash
);
    localparam int HB     = `NDN_HASH_BITS;
    localparam int NCHUNK = (64 + HB - 1) / HB;
    localparam int PAD_W  = NCHUNK * HB;

    logic [PAD_W-1:0] padded;
    logic [HB-1:0]    fold;

    // Chunk 0 is prefix[5:0], top chunk holds the last 4 bits zero extended
    always_comb begin
        padded = PAD_W'(prefix);
        fold   = '0;
        for (int i = 0; i < NCHUNK; i++) begin
            fold = fold ^ padded[i*HB +: HB];
        end
    end

    // One cycle of latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hash <= '0;
        end else begin
            hash <= fold;
        end
    end

endmodule

// ==== fib/fib_table.sv ====
// FIB engine that parses the input stream, installs routes, runs longest-prefix match and emits
`timescale 1ns/10ps

`include "ndn_params.svh"

module fib_table (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [7:0]        in_byte,
    output logic              out_valid,
    input  logic              out_ready,
    output logic [7:0]        out_byte,
    output ndn_pkg::pit_req_t pit_req,
    input  ndn_pkg::pit_rsp_t pit_rsp
);
    localparam int ROWS     = 1 << `NDN_HASH_BITS;
    localparam int OUT_BITS = 8 * `NDN_OUT_MAX_BYTES;
    localparam int PAD_BITS = OUT_BITS - 8 * `NDN_DATA_OUT_BYTES;

    ndn_pkg::fib_state_e state;
    ndn_pkg::ndn_meta_t  meta_q;
    ndn_pkg::ndn_meta_t  meta_out;

    logic [3:0]                    byte_cnt;
    logic [5:0]                    cur_len;
    logic [4:0]                    out_cnt;
    logic [63:0]                   prefix_sr;
    logic [8*`NDN_DATA_BYTES-1:0]  payload_sr;
    logic [OUT_BITS-1:0]           out_sr;
    logic [63:0]                   masked_prefix;
    logic [`NDN_HASH_BITS-1:0]     hash;
    logic                          row_hit;
    logic                          in_take;
    logic                          out_take;
    logic                          is_interest;
    logic                          emit_pkt;

    // Valid bit per (length, hash) pair
    logic [ROWS-1:0] fib_valid [`NDN_NUM_LENGTHS];

    assign in_ready  = state inside {ndn_pkg::ST_IDLE, ndn_pkg::ST_META,
                                     ndn_pkg::ST_PREFIX, ndn_pkg::ST_PAYLOAD};
    assign out_valid = (state == ndn_pkg::ST_EMIT);
    assign out_byte  = out_sr[OUT_BITS-1 -: 8];
    assign in_take   = in_valid && in_ready;
    assign out_take  = out_valid && out_ready;

    // Keep the top cur_len bits, zero the rest
    assign masked_prefix = (cur_len == 6'd0) ? 64'd0 :
                           prefix_sr & (~64'd0 << (7'd64 - {1'b0, cur_len}));

    assign row_hit     = fib_valid[cur_len][hash];
    assign is_interest = (meta_q.kind == ndn_pkg::KIND_INTEREST);
    assign meta_out    = '{kind: ndn_pkg::KIND_INTEREST, len: cur_len};

    // New interests and claimed data go out, aggregated interests and stray data do not
    assign emit_pkt = pit_rsp.done && (is_interest ? !pit_rsp.hit : pit_rsp.hit);

    prefix_hash hash_i (
        .clk    (clk),
        .rst    (rst),
        .prefix (masked_prefix),
        .hash   (hash)
    );

    // Control FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ndn_pkg::ST_IDLE;
            meta_q   <= '0;
            byte_cnt <= '0;
            cur_len  <= '0;
            out_cnt  <= '0;
            pit_req  <= '0;
        end else begin
            // Request valid is a single-cycle pulse
            pit_req.valid <= 1'b0;
            case (state)
                ndn_pkg::ST_IDLE: begin
                    if (in_take) begin
                        meta_q <= ndn_pkg::ndn_meta_t'(in_byte);
                        state  <= ndn_pkg::ST_META;
                    end
                end
                ndn_pkg::ST_META: begin
                    // Metadata held, first prefix byte arriving
                    if (in_take) begin
                        byte_cnt <= 4'd1;
                        state    <= ndn_pkg::ST_PREFIX;
                    end
                end
                ndn_pkg::ST_PREFIX: begin
                    if (in_take) begin
                        byte_cnt <= byte_cnt + 4'd1;
                        if (byte_cnt == 4'(`NDN_PREFIX_BYTES - 1)) begin
                            byte_cnt <= '0;
                            cur_len  <= meta_q.len;
                            case (meta_q.kind)
                                ndn_pkg::KIND_ROUTE:    state <= ndn_pkg::ST_HASH;
                                ndn_pkg::KIND_INTEREST: state <= ndn_pkg::ST_HASH;
                                ndn_pkg::KIND_DATA:     state <= ndn_pkg::ST_PAYLOAD;
                                default:                state <= ndn_pkg::ST_IDLE;
                            endcase
                        end
                    end
                end
                ndn_pkg::ST_PAYLOAD: begin
                    if (in_take) begin
                        byte_cnt <= byte_cnt + 4'd1;
                        if (byte_cnt == 4'(`NDN_DATA_BYTES - 1)) begin
                            pit_req <= '{valid: 1'b1, op: ndn_pkg::PIT_CLAIM,
                                         prefix: prefix_sr};
                            state   <= ndn_pkg::ST_PIT_WAIT;
                        end
                    end
                end
                ndn_pkg::ST_HASH: begin
                    // Hash of masked prefix lands at this edge
                    state <= ndn_pkg::ST_PROBE;
                end
                ndn_pkg::ST_PROBE: begin
                    if (meta_q.kind == ndn_pkg::KIND_ROUTE) begin
                        state <= ndn_pkg::ST_IDLE;
                    end else if (row_hit || cur_len == 6'd0) begin
                        pit_req <= '{valid: 1'b1, op: ndn_pkg::PIT_INSERT,
                                     prefix: prefix_sr};
                        state   <= ndn_pkg::ST_PIT_WAIT;
                    end else begin
                        // Miss, try one bit shorter
                        cur_len <= cur_len - 6'd1;
                        state   <= ndn_pkg::ST_HASH;
                    end
                end
                ndn_pkg::ST_PIT_WAIT: begin
                    if (emit_pkt) begin
                        out_cnt <= is_interest ? 5'(`NDN_OUT_MAX_BYTES)
                                               : 5'(`NDN_DATA_OUT_BYTES);
                        state   <= ndn_pkg::ST_EMIT;
                    end else if (pit_rsp.done) begin
                        state <= ndn_pkg::ST_IDLE;
                    end
                end
                ndn_pkg::ST_EMIT: begin
                    if (out_take) begin
                        out_cnt <= out_cnt - 5'd1;
                        if (out_cnt == 5'd1) begin
                            state <= ndn_pkg::ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ndn_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Route install, rows only cleared by reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NDN_NUM_LENGTHS; i++) begin
                fib_valid[i] <= '0;
            end
        end else if (state == ndn_pkg::ST_PROBE && meta_q.kind == ndn_pkg::KIND_ROUTE) begin
            fib_valid[cur_len][hash] <= 1'b1;
        end
    end

    // Byte shift registers
    always_ff @(posedge clk) begin
        if (in_take && (state == ndn_pkg::ST_META || state == ndn_pkg::ST_PREFIX)) begin
            prefix_sr <= {prefix_sr[55:0], in_byte};
        end
        if (in_take && state == ndn_pkg::ST_PAYLOAD) begin
            payload_sr <= {payload_sr[8*`NDN_DATA_BYTES-9:0], in_byte};
        end
        // Output holds while stalled, shifts one byte per accepted beat
        if (state == ndn_pkg::ST_PIT_WAIT && emit_pkt) begin
            if (is_interest) begin
                out_sr <= {meta_out, prefix_sr, masked_prefix};
            end else begin
                out_sr <= {meta_q, prefix_sr, payload_sr, {PAD_BITS{1'b0}}};
            end
        end else if (out_take) begin
            out_sr <= out_sr << 8;
        end
    end

endmodule

// ==== pit/pit_table.sv ====
// Pending interest table answering FIB insert and claim requests one cycle later
`timescale 1ns/10ps

`include "ndn_params.svh"

module pit_table (
    input  logic              clk,
    input  logic              rst,
    input  ndn_pkg::pit_req_t pit_req,
    output ndn_pkg::pit_rsp_t pit_rsp
);
    localparam int DEPTH = `NDN_PIT_DEPTH;
    localparam int IW    = $clog2(DEPTH);

    logic [63:0]      entry_prefix [DEPTH];
    logic [DEPTH-1:0] entry_valid;
    // Age rank among valid entries, 0 is newest
    logic [IW-1:0]    entry_age [DEPTH];

    logic          hit;
    logic [IW-1:0] hit_idx;
    logic          has_free;
    logic [IW-1:0] free_idx;
    logic [IW-1:0] oldest;
    logic [IW-1:0] wr_idx;
    logic          do_insert;
    logic          do_clear;

    // Scan downward so the lowest index wins
    always_comb begin
        hit      = 1'b0;
        hit_idx  = '0;
        has_free = 1'b0;
        free_idx = '0;
        oldest   = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (entry_valid[i] && entry_prefix[i] == pit_req.prefix) begin
                hit     = 1'b1;
                hit_idx = IW'(i);
            end
            if (!entry_valid[i]) begin
                has_free = 1'b1;
                free_idx = IW'(i);
            end
            // Only meaningful when full, ranks are then unique
            if (entry_age[i] == IW'(DEPTH - 1)) begin
                oldest = IW'(i);
            end
        end
    end

    assign wr_idx    = has_free ? free_idx : oldest;
    assign do_insert = pit_req.valid && pit_req.op == ndn_pkg::PIT_INSERT && !hit;
    assign do_clear  = pit_req.valid && pit_req.op == ndn_pkg::PIT_CLAIM && hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry_valid <= '0;
            pit_rsp     <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entry_age[i] <= '0;
            end
        end else begin
            pit_rsp.done <= pit_req.valid;
            pit_rsp.hit  <= pit_req.valid && hit;
            if (do_insert) begin
                entry_valid[wr_idx] <= 1'b1;
                // New entry is youngest, the rest age by one
                for (int i = 0; i < DEPTH; i++) begin
                    if (IW'(i) == wr_idx) begin
                        entry_age[i] <= '0;
                    end else if (entry_valid[i]) begin
                        entry_age[i] <= entry_age[i] + 1'b1;
                    end
                end
            end
            if (do_clear) begin
                entry_valid[hit_idx] <= 1'b0;
                // Close the gap in the age ranks
                for (int i = 0; i < DEPTH; i++) begin
                    if (entry_valid[i] && entry_age[i] > entry_age[hit_idx]) begin
                        entry_age[i] <= entry_age[i] - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_insert) begin
            entry_prefix[wr_idx] <= pit_req.prefix;
        end
    end

endmodule

// ==== hdl/ndn_router.sv ====
// NDN router top joining the FIB engine and the PIT between the input and output byte streams
`timescale 1ns/10ps

module ndn_router (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    output logic       in_ready,
    input  logic [7:0] in_byte,
    output logic       out_valid,
    input  logic       out_ready,
    output logic [7:0] out_byte
);
    // Request and response between FIB and PIT
    ndn_pkg::pit_req_t pit_req;
    ndn_pkg::pit_rsp_t pit_rsp;

    // Stream parser, match engine and serializer
    fib_table fib_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_byte   (in_byte),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_byte  (out_byte),
        .pit_req   (pit_req),
        .pit_rsp   (pit_rsp)
    );

    // Pending interests
    pit_table pit_i (
        .clk     (clk),
        .rst     (rst),
        .pit_req (pit_req),
        .pit_rsp (pit_rsp)
    );

endmodule

// ==== dv/ndn_router_clkgen.sv ====
// Testbench clock and reset source, 40 ns period with reset held for the first four cycles
`timescale 1ns/10ps

module ndn_router_clkgen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset released on the fourth rising edge
    initial begin
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== dv/ndn_router_checker.sv ====
// Output stream monitor that collects bytes per test, compares them and prints per-test results
`timescale 1ns/10ps

module ndn_router_checker (
    input  logic       clk,
    input  logic       rst,
    input  logic       out_valid,
    input  logic       out_ready,
    input  logic [7:0] out_byte,
    output int         fail_count
);
    string      cur_name;
    logic [7:0] exp_q [$];
    logic [7:0] got_q [$];
    bit         active;
    int         pass_tests;
    int         fail_tests;
    int         stray_bytes;

    assign fail_count = fail_tests + stray_bytes;

    // Byte accepted when valid and ready were both high before the edge
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (active) begin
                got_q.push_back(out_byte);
            end else begin
                stray_bytes++;
                $display("Output byte %02h appeared while no packet was in flight", out_byte);
            end
        end
    end

    task automatic begin_test(input string name);
        cur_name = name;
        exp_q.delete();
        got_q.delete();
        active = 1'b1;
    endtask

    task automatic add_expected(input logic [7:0] b);
        exp_q.push_back(b);
    endtask

    // Called once the DUT accepts input again, so the whole packet is in
    task automatic end_test();
        int first_bad;
        first_bad = -1;
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            if (first_bad < 0 && exp_q[i] != got_q[i]) begin
                first_bad = i;
            end
        end
        // One line per test, first problem only
        if (first_bad >= 0) begin
            fail_tests++;
            $display("FAIL %s byte %0d expected %02h actual %02h",
                     cur_name, first_bad, exp_q[first_bad], got_q[first_bad]);
        end else if (got_q.size() < exp_q.size()) begin
            fail_tests++;
            $display("%s is missing output, expected %0d bytes but only %0d arrived",
                     cur_name, exp_q.size(), got_q.size());
        end else if (got_q.size() > exp_q.size()) begin
            fail_tests++;
            $display("%s produced %0d extra bytes beyond the expected %0d",
                     cur_name, got_q.size() - exp_q.size(), exp_q.size());
        end else begin
            pass_tests++;
            $display("PASS %s (%0d bytes out)", cur_name, got_q.size());
        end
        active = 1'b0;
    endtask

    task automatic report_summary();
        $display("%0d tests run, %0d passed, %0d failed, %0d stray output bytes",
                 pass_tests + fail_tests, pass_tests, fail_tests, stray_bytes);
    endtask

endmodule

// ==== dv/ndn_router_asserts.sv ====
// Concurrent checks on the FIB output stream and the PIT handshake, bound into fib_table
`timescale 1ns/10ps

module ndn_router_asserts (
    input logic              clk,
    input logic              rst,
    input logic              out_valid,
    input logic              out_ready,
    input logic [7:0]        out_byte,
    input ndn_pkg::pit_req_t pit_req,
    input ndn_pkg::pit_rsp_t pit_rsp
);
    // Read by the testbench top at the end of the run
    int fail_total;

    // Back-pressure holds the byte in place
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_byte))
        else begin
            $error("out_byte changed or out_valid dropped during a stall");
            fail_total++;
        end

    // PIT answers exactly one cycle after a request
    pit_rsp_next: assert property (@(posedge clk) disable iff (rst)
        pit_req.valid |=> pit_rsp.done)
        else begin
            $error("PIT gave no response one cycle after a request");
            fail_total++;
        end

    pit_rsp_only: assert property (@(posedge clk) disable iff (rst)
        pit_rsp.done |-> $past(pit_req.valid))
        else begin
            $error("PIT response without a request on the previous cycle");
            fail_total++;
        end

    pit_req_pulse: assert property (@(posedge clk) disable iff (rst)
        pit_req.valid |=> !pit_req.valid)
        else begin
            $error("PIT request valid held longer than one cycle");
            fail_total++;
        end

endmodule

bind fib_table ndn_router_asserts asserts_i (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_byte  (out_byte),
    .pit_req   (pit_req),
    .pit_rsp   (pit_rsp)
);

// ==== dv/ndn_router_tb.sv ====
// Testbench top for the NDN router, replays the vector file with random output stalls
`timescale 1ns/10ps

module ndn_router_tb;
    localparam string VEC_FILE = "dv/ndn_router_vectors.txt";

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       in_ready;
    logic [7:0] in_byte;
    logic       out_valid;
    logic       out_ready;
    logic [7:0] out_byte;
    int         fail_count;
    int         assert_fails;
    bit         load_ok;
    int         cycle_cnt;
    int         cycle_limit;

    // Tests stored flat, with start and length per test
    string      test_name [$];
    logic [7:0] in_flat [$];
    int         in_start [$];
    int         in_len [$];
    logic [7:0] exp_flat [$];
    int         exp_start [$];
    int         exp_len [$];

    ndn_router_clkgen clkgen_i (
        .clk (clk),
        .rst (rst)
    );

    ndn_router dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_byte   (in_byte),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_byte  (out_byte)
    );

    ndn_router_checker chk_i (
        .clk        (clk),
        .rst        (rst),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_byte   (out_byte),
        .fail_count (fail_count)
    );

    // Fibonacci LFSR, taps 16 14 13 11, new bit shifted in at the bottom
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic int hex_digit(input byte c);
        int v;
        v = int'(c);
        if (v >= 48 && v <= 57) return v - 48;
        if (v >= 97 && v <= 102) return v - 87;
        if (v >= 65 && v <= 70) return v - 55;
        return -1;
    endfunction

    // Two hex digits per byte, anything else separates
    task automatic parse_bytes(input string line, input bit to_exp, output int count);
        int         nib;
        int         digits;
        logic [7:0] acc;
        count  = 0;
        digits = 0;
        acc    = '0;
        for (int i = 0; i < line.len(); i++) begin
            nib = hex_digit(line[i]);
            if (nib >= 0) begin
                acc = {acc[3:0], nib[3:0]};
                digits++;
                if (digits == 2) begin
                    if (to_exp) begin
                        exp_flat.push_back(acc);
                    end else begin
                        in_flat.push_back(acc);
                    end
                    count++;
                    digits = 0;
                end
            end else begin
                digits = 0;
            end
        end
    endtask

    task automatic load_vectors(output bit ok);
        int    fd;
        int    field;
        int    cnt;
        string line;
        string name;
        ok    = 1'b0;
        field = 0;
        fd    = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the vector file %s", VEC_FILE);
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] == "#") continue;
            case (field)
                0: begin
                    if ($sscanf(line, "%s", name) == 1) begin
                        test_name.push_back(name);
                        field = 1;
                    end
                end
                1: begin
                    in_start.push_back(in_flat.size());
                    parse_bytes(line, 1'b0, cnt);
                    in_len.push_back(cnt);
                    field = 2;
                end
                default: begin
                    exp_start.push_back(exp_flat.size());
                    parse_bytes(line, 1'b1, cnt);
                    exp_len.push_back(cnt);
                    field = 0;
                end
            endcase
        end
        $fclose(fd);
        if (field != 0 || test_name.size() == 0) begin
            $display("Vector file is empty or ends in the middle of a test");
        end else begin
            ok = 1'b1;
        end
    endtask

    task automatic run_test(input int t);
        chk_i.begin_test(test_name[t]);
        for (int i = 0; i < exp_len[t]; i++) begin
            chk_i.add_expected(exp_flat[exp_start[t] + i]);
        end
        for (int i = 0; i < in_len[t]; i++) begin
            in_valid <= 1'b1;
            in_byte  <= in_flat[in_start[t] + i];
            do @(posedge clk); while (!in_ready);
        end
        in_valid <= 1'b0;
        // in_ready drops after the last byte and returns when the packet is done
        do @(posedge clk); while (!in_ready);
        chk_i.end_test();
    endtask

    // Output stalls, about one cycle in four
    initial begin : stall_gen
        logic [15:0] lfsr;
        logic        b0;
        logic        b1;
        out_ready <= 1'b0;
        lfsr = 16'd98;
        forever begin
            @(posedge clk);
            lfsr = lfsr_step(lfsr);
            b0   = lfsr[0];
            lfsr = lfsr_step(lfsr);
            b1   = lfsr[0];
            out_ready <= !(b0 && b1);
        end
    end

    // Run limit from the test lengths, zero until vectors are loaded
    always @(posedge clk) begin
        if (!rst) begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
                $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
                $display("test failed");
                $finish;
            end
        end
    end

    initial begin
        in_valid <= 1'b0;
        in_byte  <= 8'h00;
        load_vectors(load_ok);
        if (load_ok) begin
            for (int t = 0; t < test_name.size(); t++) begin
                cycle_limit += in_len[t] + 128 + exp_len[t] * 4;
            end
            cycle_limit += 100;
            @(negedge rst);
            @(posedge clk);
            for (int t = 0; t < test_name.size(); t++) begin
                run_test(t);
            end
            repeat (4) @(posedge clk);
        end
        chk_i.report_summary();
        assert_fails = dut_i.fib_i.asserts_i.fail_total;
        if (assert_fails != 0) begin
            $display("%0d bound assertion failures in the FIB", assert_fails);
        end
        if (load_ok && fail_count == 0 && assert_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== ndn_router.f ====
+incdir+common
common/ndn_pkg.sv
hdl/prefix_hash.sv
fib/fib_table.sv
pit/pit_table.sv
hdl/ndn_router.sv
dv/ndn_router_clkgen.sv
dv/ndn_router_checker.sv
dv/ndn_router_asserts.sv
dv/ndn_router_tb.sv

// ==== Makefile ====
# Verilator build and regression run for the NDN router

VERILATOR ?= verilator
TOP       ?= ndn_router_tb
FILELIST  ?= ndn_router.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT := test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/ndn_router_vectors.txt ====
# Three lines per test: name, input bytes in hex, expected output bytes in hex
# An empty expected line means the packet produces no output
route_len8
08 AB 00 00 00 00 00 00 00

interest_hits_len8
4C AB 5F 12 34 56 78 9A BC
48 AB 5F 12 34 56 78 9A BC AB 00 00 00 00 00 00 00
route_len16
10 AB CD 00 00 00 00 00 00

interest_longest_16
58 AB CD EF 01 02 03 04 05
50 AB CD EF 01 02 03 04 05 AB CD 00 00 00 00 00 00
interest_no_route
54 12 34 56 78 9A BC DE F0
40 12 34 56 78 9A BC DE F0 00 00 00 00 00 00 00 00
data_pending_forward
80 AB 5F 12 34 56 78 9A BC 11 22 33 44
80 AB 5F 12 34 56 78 9A BC 11 22 33 44
data_repeat_dropped
80 AB 5F 12 34 56 78 9A BC 11 22 33 44

data_unrequested
80 01 02 03 04 05 06 07 08 DE AD BE EF

interest_duplicate
58 AB CD EF 01 02 03 04 05

interest_fill_1
48 AB 00 00 00 00 00 00 01
48 AB 00 00 00 00 00 00 01 AB 00 00 00 00 00 00 00
interest_fill_2
48 AB 00 00 00 00 00 00 02
48 AB 00 00 00 00 00 00 02 AB 00 00 00 00 00 00 00
interest_fill_3
48 AB 00 00 00 00 00 00 03
48 AB 00 00 00 00 00 00 03 AB 00 00 00 00 00 00 00
interest_fill_4
48 AB 00 00 00 00 00 00 04
48 AB 00 00 00 00 00 00 04 AB 00 00 00 00 00 00 00
interest_fill_5
48 AB 00 00 00 00 00 00 05
48 AB 00 00 00 00 00 00 05 AB 00 00 00 00 00 00 00
data_evicted_dropped
80 AB 00 00 00 00 00 00 01 CA FE 00 01

data_newest_forward
80 AB 00 00 00 00 00 00 05 CA FE 00 01
80 AB 00 00 00 00 00 00 05 CA FE 00 01
